// File: hw/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_count = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [$clog2(reg_count)-1:0] reg_addr_t;
  typedef logic [xlen/8-1:0] byte_mask_t;

  localparam word_t reset_pc = 32'h8000_0000;
  localparam word_t ebreak_instr = 32'h0010_0073;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef enum logic [3:0] {
    br_none,
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu,
    br_jal,
    br_jalr
  } br_op_t;

  typedef enum logic [2:0] {
    wb_alu,
    wb_imm,
    wb_pc_plus4,
    wb_load,
    wb_none
  } wb_sel_t;

  typedef enum logic [1:0] {
    size_byte, // Matches funct3[1:0] of loads and stores
    size_half,
    size_word
  } mem_size_t;

endpackage

// File: hw/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  rv_pkg::word_t     instr,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::word_t     imm,
  output rv_pkg::alu_op_t   alu_op,
  output rv_pkg::br_op_t    br_op,
  output rv_pkg::wb_sel_t   wb_sel,
  output logic              use_imm,
  output logic              use_pc,
  output logic              is_load,
  output logic              is_store,
  output logic              load_unsigned,
  output logic              halt,
  output rv_pkg::mem_size_t mem_size
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic is_reg;
  logic plain; // funct7 all zero
  logic alt;   // funct7 selects sub or sra
  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_u;
  rv_pkg::word_t imm_j;
  rv_pkg::alu_op_t arith_op;
  logic arith_ok;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign is_reg = (opcode == rv_pkg::op_reg);
  assign plain  = (funct7 == 7'b0000000);
  assign alt    = (funct7 == 7'b0100000);

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // Shared by op_imm and op_reg; only shifts check funct7 in the immediate form
  always_comb begin
    arith_op = rv_pkg::alu_add;
    arith_ok = 1'b1;
    case (funct3)
      3'b000: begin
        arith_op = (is_reg && alt) ? rv_pkg::alu_sub : rv_pkg::alu_add;
        arith_ok = !is_reg || plain || alt;
      end
      3'b001: begin
        arith_op = rv_pkg::alu_sll;
        arith_ok = plain;
      end
      3'b010: begin
        arith_op = rv_pkg::alu_slt;
        arith_ok = !is_reg || plain;
      end
      3'b011: begin
        arith_op = rv_pkg::alu_sltu;
        arith_ok = !is_reg || plain;
      end
      3'b100: begin
        arith_op = rv_pkg::alu_xor;
        arith_ok = !is_reg || plain;
      end
      3'b101: begin
        arith_op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
        arith_ok = plain || alt;
      end
      3'b110: begin
        arith_op = rv_pkg::alu_or;
        arith_ok = !is_reg || plain;
      end
      default: begin
        arith_op = rv_pkg::alu_and;
        arith_ok = !is_reg || plain;
      end
    endcase
  end

  always_comb begin
    imm           = '0;
    alu_op        = rv_pkg::alu_add;
    br_op         = rv_pkg::br_none;
    wb_sel        = rv_pkg::wb_none; // Unknown encodings fall through as no-ops
    use_imm       = 1'b0;
    use_pc        = 1'b0;
    is_load       = 1'b0;
    is_store      = 1'b0;
    load_unsigned = 1'b0;
    halt          = 1'b0;
    mem_size      = rv_pkg::size_word;
    case (opcode)
      rv_pkg::op_lui: begin
        imm    = imm_u;
        wb_sel = rv_pkg::wb_imm;
      end
      rv_pkg::op_auipc: begin
        imm     = imm_u;
        use_pc  = 1'b1;
        use_imm = 1'b1;
        wb_sel  = rv_pkg::wb_alu;
      end
      rv_pkg::op_jal: begin
        imm    = imm_j;
        br_op  = rv_pkg::br_jal;
        wb_sel = rv_pkg::wb_pc_plus4;
      end
      rv_pkg::op_jalr: if (funct3 == 3'b000) begin
        imm     = imm_i;
        use_imm = 1'b1;
        br_op   = rv_pkg::br_jalr;
        wb_sel  = rv_pkg::wb_pc_plus4;
      end
      rv_pkg::op_branch: begin
        imm = imm_b;
        case (funct3)
          3'b000:  br_op = rv_pkg::br_eq;
          3'b001:  br_op = rv_pkg::br_ne;
          3'b100:  br_op = rv_pkg::br_lt;
          3'b101:  br_op = rv_pkg::br_ge;
          3'b110:  br_op = rv_pkg::br_ltu;
          3'b111:  br_op = rv_pkg::br_geu;
          default: br_op = rv_pkg::br_none;
        endcase
      end
      rv_pkg::op_load: if (funct3[1:0] != 2'b11 && funct3[2:1] != 2'b11) begin
        imm           = imm_i;
        use_imm       = 1'b1;
        is_load       = 1'b1;
        load_unsigned = funct3[2];
        mem_size      = rv_pkg::mem_size_t'(funct3[1:0]);
        wb_sel        = rv_pkg::wb_load;
      end
      rv_pkg::op_store: if (!funct3[2] && funct3[1:0] != 2'b11) begin
        imm      = imm_s;
        use_imm  = 1'b1;
        is_store = 1'b1;
        mem_size = rv_pkg::mem_size_t'(funct3[1:0]);
      end
      rv_pkg::op_imm: if (arith_ok) begin
        imm     = imm_i;
        use_imm = 1'b1;
        alu_op  = arith_op;
        wb_sel  = rv_pkg::wb_alu;
      end
      rv_pkg::op_reg: if (arith_ok) begin
        alu_op = arith_op;
        wb_sel = rv_pkg::wb_alu;
      end
      rv_pkg::op_system: halt = (instr == rv_pkg::ebreak_instr); // ecall is a no-op
      default: ;
    endcase
  end

endmodule

// File: hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::reg_addr_t raddr1,
  input  rv_pkg::reg_addr_t raddr2,
  input  rv_pkg::reg_addr_t waddr,
  input  logic              wen,
  input  rv_pkg::word_t     wdata,
  output rv_pkg::word_t     rdata1,
  output rv_pkg::word_t     rdata2
);

  rv_pkg::word_t regs [rv_pkg::reg_count];

  // x0 is never stored, so its read is forced
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

  always_ff @(posedge clk) begin
    if (wen && !reset && waddr != '0) begin // No retire while in reset
      regs[waddr] <= wdata;
    end
  end

endmodule

// File: hw/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input  logic            clk,
  input  logic            reset,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   imm,
  input  rv_pkg::alu_op_t alu_op,
  input  rv_pkg::br_op_t  br_op,
  input  logic            use_imm,
  input  logic            use_pc,
  input  logic            halt,
  output rv_pkg::word_t   pc,
  output rv_pkg::word_t   alu_out,
  output rv_pkg::word_t   pc_plus4
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  rv_pkg::word_t branch_target;
  rv_pkg::word_t jalr_target;
  rv_pkg::word_t next_pc;
  logic [4:0] shamt;
  logic taken;

  assign op_a  = use_pc ? pc : rs1_data;
  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0]; // Only the low 5 bits shift

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:  alu_out = op_a + op_b;
      rv_pkg::alu_sub:  alu_out = op_a - op_b;
      rv_pkg::alu_sll:  alu_out = op_a << shamt;
      rv_pkg::alu_slt:  alu_out = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
      rv_pkg::alu_sltu: alu_out = rv_pkg::word_t'(op_a < op_b);
      rv_pkg::alu_xor:  alu_out = op_a ^ op_b;
      rv_pkg::alu_srl:  alu_out = op_a >> shamt;
      rv_pkg::alu_sra:  alu_out = $signed(op_a) >>> shamt;
      rv_pkg::alu_or:   alu_out = op_a | op_b;
      rv_pkg::alu_and:  alu_out = op_a & op_b;
      default:          alu_out = op_a + op_b;
    endcase
  end

  // Compares registers directly, the ALU is free for the address
  always_comb begin
    case (br_op)
      rv_pkg::br_eq:  taken = (rs1_data == rs2_data);
      rv_pkg::br_ne:  taken = (rs1_data != rs2_data);
      rv_pkg::br_lt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::br_ge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::br_ltu: taken = (rs1_data < rs2_data);
      rv_pkg::br_geu: taken = (rs1_data >= rs2_data);
      rv_pkg::br_jal: taken = 1'b1;
      default:        taken = 1'b0;
    endcase
  end

  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc + imm;
  assign jalr_target   = (rs1_data + imm) & 32'hffff_fffe; // Bit 0 cleared

  always_comb begin
    if (br_op == rv_pkg::br_jalr) begin
      next_pc = jalr_target;
    end else if (taken) begin
      next_pc = branch_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= rv_pkg::reset_pc;
    end else if (!halt) begin // Parked on ebreak
      pc <= next_pc;
    end
  end

endmodule

// File: hw/rv_result.sv
`timescale 1ns/1ps

module rv_result (
  input  rv_pkg::wb_sel_t    wb_sel,
  input  rv_pkg::mem_size_t  mem_size,
  input  logic               load_unsigned,
  input  logic               is_load,
  input  logic               is_store,
  input  logic               halt,
  input  rv_pkg::word_t      alu_out,
  input  rv_pkg::word_t      pc_plus4,
  input  rv_pkg::word_t      imm,
  input  rv_pkg::word_t      rs2_data,
  input  rv_pkg::word_t      mem_rdata,
  output rv_pkg::word_t      rd_data,
  output logic               rd_wen,
  output logic               mem_ren,
  output logic               mem_wen,
  output rv_pkg::byte_mask_t mem_wmask,
  output rv_pkg::word_t      mem_wdata
);

  logic [4:0] lane_shift;
  rv_pkg::word_t load_lane;
  rv_pkg::word_t load_data;
  rv_pkg::byte_mask_t size_mask;

  assign lane_shift = {alu_out[1:0], 3'b000}; // Byte offset in bits
  assign load_lane  = mem_rdata >> lane_shift;

  always_comb begin
    case (mem_size)
      rv_pkg::size_byte: load_data = {{24{load_lane[7] & ~load_unsigned}}, load_lane[7:0]};
      rv_pkg::size_half: load_data = {{16{load_lane[15] & ~load_unsigned}}, load_lane[15:0]};
      default:           load_data = mem_rdata;
    endcase
  end

  always_comb begin
    case (mem_size)
      rv_pkg::size_byte: size_mask = 4'b0001;
      rv_pkg::size_half: size_mask = 4'b0011;
      default:           size_mask = 4'b1111;
    endcase
  end

  assign mem_ren   = is_load && !halt;
  assign mem_wen   = is_store && !halt;
  assign mem_wdata = rs2_data << lane_shift; // Data moved into its lane
  assign mem_wmask = mem_wen ? size_mask << alu_out[1:0] : '0;

  always_comb begin
    case (wb_sel)
      rv_pkg::wb_alu:      rd_data = alu_out;
      rv_pkg::wb_imm:      rd_data = imm;
      rv_pkg::wb_pc_plus4: rd_data = pc_plus4;
      rv_pkg::wb_load:     rd_data = load_data;
      default:             rd_data = '0;
    endcase
  end

  assign rd_wen = (wb_sel != rv_pkg::wb_none) && !halt;

endmodule

// File: hw/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic               clk,
  input  logic               reset,
  output rv_pkg::word_t      pc,
  input  rv_pkg::word_t      instr,
  output rv_pkg::word_t      mem_addr,
  output logic               mem_ren,
  output logic               mem_wen,
  output rv_pkg::byte_mask_t mem_wmask,
  output rv_pkg::word_t      mem_wdata,
  input  rv_pkg::word_t      mem_rdata,
  output logic               halt
);

  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::reg_addr_t rd;
  rv_pkg::word_t     imm;
  rv_pkg::alu_op_t   alu_op;
  rv_pkg::br_op_t    br_op;
  rv_pkg::wb_sel_t   wb_sel;
  rv_pkg::mem_size_t mem_size;
  logic              use_imm;
  logic              use_pc;
  logic              is_load;
  logic              is_store;
  logic              load_unsigned;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  rv_pkg::word_t     alu_out;
  rv_pkg::word_t     pc_plus4;
  rv_pkg::word_t     rd_data;
  logic              rd_wen;

  assign mem_addr = alu_out; // Loads and stores share the ALU sum

  rv_decode u_decode (
    .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .alu_op(alu_op), .br_op(br_op), .wb_sel(wb_sel),
    .use_imm(use_imm), .use_pc(use_pc), .is_load(is_load), .is_store(is_store),
    .load_unsigned(load_unsigned), .halt(halt), .mem_size(mem_size)
  );

  rv_regfile u_regfile (
    .clk(clk), .reset(reset), .raddr1(rs1), .raddr2(rs2), .waddr(rd),
    .wen(rd_wen), .wdata(rd_data), .rdata1(rs1_data), .rdata2(rs2_data)
  );

  rv_execute u_execute (
    .clk(clk), .reset(reset), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
    .alu_op(alu_op), .br_op(br_op), .use_imm(use_imm), .use_pc(use_pc), .halt(halt),
    .pc(pc), .alu_out(alu_out), .pc_plus4(pc_plus4)
  );

  rv_result u_result (
    .wb_sel(wb_sel), .mem_size(mem_size), .load_unsigned(load_unsigned),
    .is_load(is_load), .is_store(is_store), .halt(halt),
    .alu_out(alu_out), .pc_plus4(pc_plus4), .imm(imm), .rs2_data(rs2_data),
    .mem_rdata(mem_rdata), .rd_data(rd_data), .rd_wen(rd_wen),
    .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_wmask(mem_wmask), .mem_wdata(mem_wdata)
  );

endmodule

// File: test/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  logic clk;
  logic reset;
  logic mem_ren, mem_wen, halt;
  rv_pkg::word_t pc, instr, mem_addr, mem_wdata, mem_rdata;
  rv_pkg::byte_mask_t mem_wmask;

  rv_pkg::word_t imem [512];
  rv_pkg::word_t dmem [512];
  rv_pkg::word_t m_mem [512]; // Model copy of data memory
  rv_pkg::word_t m_regs [32];
  rv_pkg::word_t m_pc, exp_pc, exp_addr, exp_wdata, lfsr;
  rv_pkg::byte_mask_t exp_mask;
  logic exp_ren, exp_wen, exp_halt;
  int prog_len, slot, cycles, cycle_limit, halt_cycles;

  rv_core DUT (
    .clk(clk), .reset(reset), .pc(pc), .instr(instr), .mem_addr(mem_addr),
    .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_wmask(mem_wmask),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .halt(halt)
  );

  always #4 clk = ~clk;

  // reset_pc leaves bits 10:2 clear, so pc indexes directly
  assign instr     = imem[pc[10:2]];
  assign mem_rdata = dmem[mem_addr[10:2]];

  function automatic rv_pkg::word_t lanes(input rv_pkg::byte_mask_t m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  always @(posedge clk) begin
    if (mem_wen === 1'b1) begin
      dmem[mem_addr[10:2]] <= (dmem[mem_addr[10:2]] & ~lanes(mem_wmask))
                              | (mem_wdata & lanes(mem_wmask));
    end
  end

  function automatic rv_pkg::word_t rand_bits(input int n);
    rv_pkg::word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1; // Galois step
    end
    return v;
  endfunction

  task automatic emit(input rv_pkg::word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  task automatic emit_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                        input logic [2:0] f3, input logic [4:0] rd);
    emit({f7, rs2, rs1, f3, rd, rv_pkg::op_reg});
  endtask

  task automatic emit_i(input logic [6:0] op, input logic [11:0] imm, input logic [4:0] rs1,
                        input logic [2:0] f3, input logic [4:0] rd);
    emit({imm, rs1, f3, rd, op});
  endtask

  task automatic emit_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                        input logic [2:0] f3);
    emit({imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::op_store});
  endtask

  task automatic emit_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                        input logic [2:0] f3);
    emit({imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::op_branch});
  endtask

  task automatic emit_u(input logic [6:0] op, input logic [19:0] imm, input logic [4:0] rd);
    emit({imm, rd, op});
  endtask

  task automatic emit_j(input logic [20:0] imm, input logic [4:0] rd);
    emit({imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::op_jal});
  endtask

  task automatic load_const(input logic [4:0] rd, input rv_pkg::word_t v);
    emit_u(rv_pkg::op_lui, v[31:12] + v[11], rd); // Rounded for the signed addi
    emit_i(rv_pkg::op_imm, v[11:0], rd, 3'b000, rd);
  endtask

  task automatic store_reg(input logic [4:0] rs);
    emit_s(slot[11:0], rs, 5'd31, 3'b010);
    slot = (slot + 4) % 2048;
  endtask

  task automatic build_program();
    rv_pkg::word_t a, b, v;
    load_const(31, 32'h0000_1000); // Data base
    for (int r = 0; r < 4; r++) begin
      a = (r == 0) ? 32'h8000_0000 : (r == 1) ? 32'hffff_ffff : rand_bits(32);
      b = (r == 0) ? 32'h7fff_ffff : (r == 1) ? 32'h0000_0025 : rand_bits(32);
      load_const(1, a);
      load_const(2, b);
      for (int f = 0; f < 8; f++) begin
        emit_r(7'h00, 2, 1, f[2:0], 3);
        store_reg(3);
        if (f == 0 || f == 5) begin
          emit_r(7'h20, 2, 1, f[2:0], 3); // sub, sra
          store_reg(3);
        end
        if (f == 1 || f == 5) begin
          v = rand_bits(5);
          emit_i(rv_pkg::op_imm, {7'h00, v[4:0]}, 1, f[2:0], 3);
          store_reg(3);
          if (f == 5) begin
            emit_i(rv_pkg::op_imm, {7'h20, v[4:0]}, 1, 3'b101, 3);
            store_reg(3);
          end
        end else begin
          v = rand_bits(12);
          emit_i(rv_pkg::op_imm, v[11:0], 1, f[2:0], 3);
          store_reg(3);
        end
      end
    end
    v = rand_bits(20);
    emit_u(rv_pkg::op_lui, v[19:0], 4);
    store_reg(4);
    emit_u(rv_pkg::op_auipc, v[19:0], 4);
    store_reg(4);
    for (int p = 0; p < 3; p++) begin
      v = rand_bits(32);
      load_const(1, p == 0 ? 32'h8000_0000 : p == 1 ? 32'h7fff_ffff : v);
      load_const(2, p == 0 ? 32'h7fff_ffff : p == 1 ? 32'h8000_0000 : v);
      for (int f = 0; f < 8; f++) begin
        if (f != 2 && f != 3) begin
          emit_i(rv_pkg::op_imm, 12'd0, 0, 3'b000, 5);
          emit_b(13'd8, 2, 1, f[2:0]);
          emit_i(rv_pkg::op_imm, 12'd1, 0, 3'b000, 5); // Only on fall-through
          store_reg(5);
        end
      end
    end
    emit_j(21'd8, 6);
    emit_i(rv_pkg::op_imm, 12'd1, 0, 3'b000, 5);
    store_reg(6);
    emit_u(rv_pkg::op_auipc, 20'd0, 7);
    emit_i(rv_pkg::op_jalr, 12'd13, 7, 3'b000, 8); // Odd target lands 12 past auipc
    emit_i(rv_pkg::op_imm, 12'd2, 0, 3'b000, 5);
    store_reg(8);
    store_reg(5);
    load_const(9, rand_bits(32) | 32'h0000_8080);
    for (int off = 0; off < 4; off++) begin
      emit_s(12'hff0 + off[11:0], 9, 31, 3'b000);
      emit_i(rv_pkg::op_imm, 12'h063, 9, 3'b000, 9);
    end
    emit_s(12'hff4, 9, 31, 3'b001);
    emit_i(rv_pkg::op_imm, 12'h2c5, 9, 3'b000, 9);
    emit_s(12'hff6, 9, 31, 3'b001);
    for (int off = 0; off < 4; off++) begin
      emit_i(rv_pkg::op_load, 12'hff0 + off[11:0], 31, 3'b000, 10);
      store_reg(10);
      emit_i(rv_pkg::op_load, 12'hff0 + off[11:0], 31, 3'b100, 10);
      store_reg(10);
    end
    for (int off = 0; off < 4; off += 2) begin
      emit_i(rv_pkg::op_load, 12'hff4 + off[11:0], 31, 3'b001, 10);
      store_reg(10);
      emit_i(rv_pkg::op_load, 12'hff4 + off[11:0], 31, 3'b101, 10);
      store_reg(10);
      emit_i(rv_pkg::op_load, 12'hff0 + {off[10:0], 1'b0}, 31, 3'b010, 10); // lw of both words
      store_reg(10);
    end
    emit_i(rv_pkg::op_imm, 12'h123, 0, 3'b000, 0);
    emit_u(rv_pkg::op_lui, 20'habcde, 0);
    store_reg(0);
    emit(32'h0000_0000); // Unknown opcode
    emit(32'h0010_0073); // ebreak
    store_reg(1);
  endtask

  function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::word_t a, b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input rv_pkg::word_t a, b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic void ref_step(input rv_pkg::word_t ins);
    rv_pkg::word_t a, b, imm_i, imm_s, imm_b, res, addr, lane, nxt;
    logic wr;
    a = m_regs[ins[19:15]];
    b = m_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    res = '0;
    wr = 1'b0;
    nxt = m_pc + 4;
    exp_pc = m_pc;
    exp_ren = 1'b0;
    exp_wen = 1'b0;
    exp_halt = 1'b0;
    exp_mask = '0;
    exp_addr = '0;
    exp_wdata = '0;
    case (ins[6:0])
      rv_pkg::op_lui: begin
        res = {ins[31:12], 12'b0};
        wr = 1'b1;
      end
      rv_pkg::op_auipc: begin
        res = m_pc + {ins[31:12], 12'b0};
        wr = 1'b1;
      end
      rv_pkg::op_jal: begin
        res = m_pc + 4;
        wr = 1'b1;
        nxt = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      rv_pkg::op_jalr: begin
        res = m_pc + 4;
        wr = 1'b1;
        nxt = (a + imm_i) & ~32'd1;
      end
      rv_pkg::op_branch: if (branch_taken(ins[14:12], a, b)) nxt = m_pc + imm_b;
      rv_pkg::op_load: begin
        addr = a + imm_i;
        lane = m_mem[addr[10:2]] >> (8 * addr[1:0]);
        case (ins[14:12])
          3'b000: res = {{24{lane[7]}}, lane[7:0]};
          3'b001: res = {{16{lane[15]}}, lane[15:0]};
          3'b100: res = {24'b0, lane[7:0]};
          3'b101: res = {16'b0, lane[15:0]};
          default: res = lane;
        endcase
        exp_ren = 1'b1;
        exp_addr = addr;
        wr = 1'b1;
      end
      rv_pkg::op_store: begin
        exp_addr = a + imm_s;
        exp_wen = 1'b1;
        exp_mask = ins[13] ? 4'b1111 : ins[12] ? 4'b0011 << exp_addr[1:0]
                                              : 4'b0001 << exp_addr[1:0];
        exp_wdata = b << (8 * exp_addr[1:0]);
        m_mem[exp_addr[10:2]] = (m_mem[exp_addr[10:2]] & ~lanes(exp_mask))
                                | (exp_wdata & lanes(exp_mask));
      end
      rv_pkg::op_imm: begin
        res = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
        wr = 1'b1;
      end
      rv_pkg::op_reg: begin
        res = alu_ref(ins[14:12], ins[30], a, b);
        wr = 1'b1;
      end
      rv_pkg::op_system: begin
        exp_halt = (ins == 32'h0010_0073);
        if (exp_halt) nxt = m_pc;
      end
      default: ;
    endcase
    if (wr && ins[11:7] != 5'd0) m_regs[ins[11:7]] = res;
    m_pc = nxt;
  endfunction

  task automatic report_mismatch(input string field, input rv_pkg::word_t got,
                                 input rv_pkg::word_t want);
    $display("Error at %0t ns: %s is %h, expected %h", $time, field, got, want);
    $display("tests failed");
    $fatal(1, "mismatch on %s", field);
  endtask

  always @(posedge clk) begin
    if (!reset) begin
      cycles++;
      if (cycles > cycle_limit) begin
        $display("Error at %0t ns: core did not reach ebreak in %0d cycles", $time, cycle_limit);
        $display("tests failed");
        $fatal(1, "timeout");
      end
      ref_step(imem[m_pc[10:2]]);
      assert (pc === exp_pc) else report_mismatch("pc", pc, exp_pc);
      assert (halt === exp_halt) else report_mismatch("halt", halt, exp_halt);
      assert (mem_ren === exp_ren) else report_mismatch("mem_ren", mem_ren, exp_ren);
      assert (mem_wen === exp_wen) else report_mismatch("mem_wen", mem_wen, exp_wen);
      if (exp_ren || exp_wen) begin
        assert (mem_addr === exp_addr) else report_mismatch("mem_addr", mem_addr, exp_addr);
      end
      if (exp_wen) begin
        assert (mem_wmask === exp_mask) else report_mismatch("mem_wmask", mem_wmask, exp_mask);
        assert ((mem_wdata & lanes(exp_mask)) === (exp_wdata & lanes(exp_mask)))
          else report_mismatch("mem_wdata", mem_wdata & lanes(exp_mask),
                               exp_wdata & lanes(exp_mask));
      end
      if (exp_halt) halt_cycles++;
      if (halt_cycles == 4) begin // Parked long enough to see pc and strobes hold
        $display("all tests passed");
        $finish;
      end
    end
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    lfsr = 32'h28c7_a522;
    prog_len = 0;
    slot = 0;
    cycles = 0;
    halt_cycles = 0;
    m_pc = rv_pkg::reset_pc;
    for (int i = 0; i < 512; i++) begin
      imem[i] = '0;
      dmem[i] = (i * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
      m_mem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) m_regs[i] = '0;
    build_program();
    cycle_limit = prog_len * 2;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: verilog.f
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_core.sv
test/rv_core_tb.sv
